//--- sources.f
+incdir+testbench
src/rv_pkg.sv
src/instruction_memory.sv
src/program_loader.sv
src/register_file.sv
src/instruction_decoder.sv
src/data_memory.sv
src/rv_core.sv
src/rv_top.sv
testbench/tb_rv_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --timing -f sources.f --top-module tb_rv_top \
    -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$log_file"; then
    echo "simulation reported errors, see $log_file"
    exit 1
fi

echo "simulation finished without errors"
exit 0

//--- testbench/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// architectural state of the reference model
logic [31:0] model_regs [0:31];
logic [31:0] model_mem  [0:255];
logic [31:0] model_pc;
integer      seed = 32'h4a25_cab0;
int          stored_q [$];  // data word offsets already written by a sw

// what the last model step expects on the trace
logic        exp_illegal;
logic        exp_rd_we;
logic [4:0]  exp_rd;
logic [31:0] exp_rd_data;
logic        exp_st_we;
logic [7:0]  exp_st_addr;
logic [31:0] exp_st_data;

task automatic reset_model();
    for (int i = 0; i < 32; i++)
    begin
        model_regs[i] = 32'd0;
    end
    model_pc = 32'd0;
endtask

// one random word, mostly legal, about one in sixteen illegal
task automatic random_instr(output logic [31:0] w);
    int          kind;
    int          off;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    kind = $unsigned($random(seed)) % 16;
    rd   = 5'($random(seed));
    rs1  = 5'($random(seed));
    rs2  = 5'($random(seed));
    imm  = 12'($random(seed) % 64);           // small, either sign
    off  = $unsigned($random(seed)) % 256;    // data word offset
    if (kind >= 13 && kind <= 14 && stored_q.size() == 0)
        kind = 11;                            // nothing to read back yet
    case (kind)
        0, 1: w = {imm, rs1, rv_pkg::F3_ADD_SUB, rd, rv_pkg::OPC_OP_IMM};
        2:    w = {imm, rs1, rv_pkg::F3_AND, rd, rv_pkg::OPC_OP_IMM};
        3:    w = {imm, rs1, rv_pkg::F3_OR, rd, rv_pkg::OPC_OP_IMM};
        4:    w = {imm, rs1, rv_pkg::F3_XOR, rd, rv_pkg::OPC_OP_IMM};
        5, 6: w = {7'd0, rs2, rs1, rv_pkg::F3_ADD_SUB, rd, rv_pkg::OPC_OP};
        7:    w = {rv_pkg::F7_SUB, rs2, rs1, rv_pkg::F3_ADD_SUB, rd, rv_pkg::OPC_OP};
        8:    w = {7'd0, rs2, rs1, rv_pkg::F3_AND, rd, rv_pkg::OPC_OP};
        9:    w = {7'd0, rs2, rs1, rv_pkg::F3_OR, rd, rv_pkg::OPC_OP};
        10:   w = {7'd0, rs2, rs1, rv_pkg::F3_XOR, rd, rv_pkg::OPC_OP};
        11, 12:
        begin
            imm = 12'(off * 4);               // x0 base, word aligned
            w   = {imm[11:5], rs2, 5'd0, rv_pkg::F3_WORD, imm[4:0], rv_pkg::OPC_STORE};
            stored_q.push_back(off);
        end
        13, 14:
        begin
            off = stored_q[$unsigned($random(seed)) % stored_q.size()];
            imm = 12'(off * 4);
            w   = {imm, 5'd0, rv_pkg::F3_WORD, rd, rv_pkg::OPC_LOAD};
        end
        default:
        begin
            case ($unsigned($random(seed)) % 4)
                0:       w = 32'd0;                                         // zero word
                1:       w = {imm, rs1, 3'b010, rd, rv_pkg::OPC_OP_IMM};    // slti
                2:       w = {imm, rs1, 3'b000, rd, rv_pkg::OPC_LOAD};      // lb
                default: w = {imm, rs1, 3'b000, rd, 7'b110_1111};           // jal opcode
            endcase
        end
    endcase
endtask

function automatic logic [31:0] apply_op(input logic [2:0] f3, input logic sub,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
        rv_pkg::F3_XOR: return a ^ b;
        rv_pkg::F3_OR:  return a | b;
        rv_pkg::F3_AND: return a & b;
        default:        return sub ? a - b : a + b;
    endcase
endfunction

// executes one word against the model and fills the exp_ trace fields
task automatic step_model(input logic [31:0] w);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] res;
    logic        legal;
    opc   = w[6:0];
    f3    = w[14:12];
    f7    = w[31:25];
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    legal = 1'b0;
    res   = 32'd0;
    exp_st_we   = 1'b0;
    exp_st_addr = 8'd0;
    exp_st_data = 32'd0;
    case (opc)
        rv_pkg::OPC_OP_IMM:
        begin
            legal = f3 inside {rv_pkg::F3_ADD_SUB, rv_pkg::F3_XOR, rv_pkg::F3_OR, rv_pkg::F3_AND};
            res   = apply_op(f3, 1'b0, a, {{20{w[31]}}, w[31:20]});
        end
        rv_pkg::OPC_OP:
        begin
            legal = (f7 == 7'd0 && f3 inside {rv_pkg::F3_ADD_SUB, rv_pkg::F3_XOR,
                                               rv_pkg::F3_OR, rv_pkg::F3_AND})
                 || (f7 == rv_pkg::F7_SUB && f3 == rv_pkg::F3_ADD_SUB);
            res   = apply_op(f3, f7 == rv_pkg::F7_SUB, a, b);
        end
        rv_pkg::OPC_LOAD:
        begin
            legal = (f3 == rv_pkg::F3_WORD);
            ea    = a + {{20{w[31]}}, w[31:20]};
            res   = model_mem[ea[9:2]];
        end
        rv_pkg::OPC_STORE:
        begin
            legal       = (f3 == rv_pkg::F3_WORD);
            ea          = a + {{20{w[31]}}, w[31:25], w[11:7]};
            exp_st_we   = legal;
            exp_st_addr = ea[9:2];
            exp_st_data = b;
        end
        default: legal = 1'b0;
    endcase
    exp_illegal = !legal;
    exp_rd      = w[11:7];
    exp_rd_we   = legal && opc != rv_pkg::OPC_STORE && exp_rd != 5'd0;  // x0 never written
    exp_rd_data = res;
    if (exp_rd_we)
        model_regs[exp_rd] = res;
    if (exp_st_we)
        model_mem[exp_st_addr] = exp_st_data;
    model_pc = (model_pc + 32'd4) % 32'd4096;  // 1024 words then wrap
endtask

`endif

//--- testbench/tb_rv_top.sv
module tb_rv_top;

    localparam int PROG_LEN  = 200;  // words loaded
    localparam int RUN_LEN   = 220;  // retirements checked, zero tail included
    localparam int WATCH_CYC = PROG_LEN * 6 + RUN_LEN + 50;

    logic               clk = 1'b0;
    logic               rst;
    logic               load_req;
    rv_pkg::imem_addr_t load_addr;
    rv_pkg::word_t      load_data;
    logic               load_ack;
    logic               start;
    logic               retire_valid;
    rv_pkg::pc_t        retire_pc;
    rv_pkg::word_t      retire_instr;
    logic               retire_illegal;
    logic               retire_rd_we;
    rv_pkg::reg_idx_t   retire_rd;
    rv_pkg::word_t      retire_rd_data;
    logic               retire_st_we;
    rv_pkg::dmem_addr_t retire_st_addr;
    rv_pkg::word_t      retire_st_data;

    logic [31:0] prog [0:1023];  // expected instruction memory image
    int          errors = 0;
    int          checks = 0;

    `include "rv_model.svh"

    rv_top rv_top_inst
    (
        .clk            (clk),
        .rst            (rst),
        .load_req       (load_req),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .load_ack       (load_ack),
        .start          (start),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_instr   (retire_instr),
        .retire_illegal (retire_illegal),
        .retire_rd_we   (retire_rd_we),
        .retire_rd      (retire_rd),
        .retire_rd_data (retire_rd_data),
        .retire_st_we   (retire_st_we),
        .retire_st_addr (retire_st_addr),
        .retire_st_data (retire_st_data)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("FAIL %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic string class_name(input logic [31:0] w, input logic illegal);
        if (illegal)
            return "illegal";
        case (w[6:0])
            rv_pkg::OPC_OP_IMM: return "op_imm";
            rv_pkg::OPC_OP:     return "op";
            rv_pkg::OPC_LOAD:   return "lw";
            default:            return "sw";
        endcase
    endfunction

    // one four-phase transfer, entered and left 10 units after an edge
    task automatic load_word(input int idx);
        int waited;
        assert (load_ack === 1'b0)
        else
        begin
            errors++;
            $display("load_ack already high before req for word %0d", idx);
        end
        load_req  = 1'b1;
        load_addr = rv_pkg::imem_addr_t'(idx);
        load_data = prog[idx];
        waited    = 0;
        while (load_ack !== 1'b1 && waited < 8)
        begin
            @(posedge clk);
            #10;
            waited++;
        end
        check_value($sformatf("load %0d ack rise", idx), 32'd2, waited);  // write, then ack
        load_req = 1'b0;
        waited   = 0;
        while (load_ack !== 1'b0 && waited < 8)
        begin
            @(posedge clk);
            #10;
            waited++;
        end
        check_value($sformatf("load %0d ack fall", idx), 32'd1, waited);
    endtask

    task automatic check_retire(input int n);
        logic [31:0] pc_exp;
        logic [31:0] w;
        string       tag;
        pc_exp = model_pc;
        w      = prog[pc_exp[11:2]];
        step_model(w);
        tag = $sformatf("%s #%0d", class_name(w, exp_illegal), n);
        check_value({tag, " pc"}, pc_exp, retire_pc);
        check_value({tag, " instr"}, w, retire_instr);
        check_value({tag, " illegal"}, 32'(exp_illegal), 32'(retire_illegal));
        check_value({tag, " rd_we"}, 32'(exp_rd_we), 32'(retire_rd_we));
        check_value({tag, " st_we"}, 32'(exp_st_we), 32'(retire_st_we));
        if (exp_rd_we)
        begin
            check_value({tag, " rd"}, 32'(exp_rd), 32'(retire_rd));
            check_value({tag, " rd_data"}, exp_rd_data, retire_rd_data);
        end
        if (exp_st_we)
        begin
            check_value({tag, " st_addr"}, 32'(exp_st_addr), 32'(retire_st_addr));
            check_value({tag, " st_data"}, exp_st_data, retire_st_data);
        end
    endtask

    task automatic run_and_check();
        int cycles;
        int retired;
        cycles  = 0;
        retired = 0;
        while (retired < RUN_LEN)
        begin
            @(posedge clk);
            #10;
            cycles++;
            if (cycles == 1)
            begin
                start     = 1'b0;
                load_req  = 1'b1;  // loader must ignore this once running
                load_addr = 10'h3ff;
                load_data = 32'hffff_ffff;
            end
            assert (load_ack === 1'b0)
            else
            begin
                errors++;
                $display("load_ack went high while the core was running");
            end
            if (retire_valid === 1'b1)
            begin
                if (retired == 0)
                    check_value("start to first retire", 32'd2, cycles);
                check_retire(retired);
                retired++;
            end
            else
            begin
                assert (retired == 0)
                else
                begin
                    errors++;
                    $display("retire_valid dropped after %0d retirements", retired);
                end
            end
        end
        load_req = 1'b0;
    endtask

    initial
    begin
        #(WATCH_CYC * 100);
        $display("watchdog expired after %0d cycles, run did not complete", WATCH_CYC);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        rst       = 1'b1;
        load_req  = 1'b0;
        load_addr = '0;
        load_data = '0;
        start     = 1'b0;
        for (int i = 0; i < 1024; i++)
        begin
            prog[i] = 32'd0;  // unloaded tail stays zero
        end
        for (int i = 0; i < PROG_LEN; i++)
        begin
            random_instr(prog[i]);
        end
        reset_model();
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int i = 0; i < PROG_LEN; i++)
        begin
            load_word(i);
        end
        start = 1'b1;
        run_and_check();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- src/rv_top.sv
module rv_top
(
    input  logic               clk,
    input  logic               rst,
    input  logic               load_req,
    input  rv_pkg::imem_addr_t load_addr,
    input  rv_pkg::word_t      load_data,
    output logic               load_ack,
    input  logic               start,
    output logic               retire_valid,
    output rv_pkg::pc_t        retire_pc,
    output rv_pkg::word_t      retire_instr,
    output logic               retire_illegal,
    output logic               retire_rd_we,
    output rv_pkg::reg_idx_t   retire_rd,
    output rv_pkg::word_t      retire_rd_data,
    output logic               retire_st_we,
    output rv_pkg::dmem_addr_t retire_st_addr,
    output rv_pkg::word_t      retire_st_data
);

    logic               imem_we;     // loader side
    rv_pkg::imem_addr_t imem_waddr;
    rv_pkg::word_t      imem_wdata;
    logic               run;
    rv_pkg::imem_addr_t imem_addr;   // fetch side
    rv_pkg::word_t      instr;
    rv_pkg::dmem_addr_t dmem_addr;
    logic               dmem_we;
    rv_pkg::word_t      dmem_wdata;
    rv_pkg::word_t      dmem_rdata;

    program_loader program_loader_inst
    (
        .clk        (clk),
        .rst        (rst),
        .load_req   (load_req),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .load_ack   (load_ack),
        .start      (start),
        .imem_we    (imem_we),
        .imem_waddr (imem_waddr),
        .imem_wdata (imem_wdata),
        .run        (run)
    );

    instruction_memory instruction_memory_inst
    (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_waddr),
        .wdata (imem_wdata),
        .raddr (imem_addr),
        .rdata (instr)
    );

    data_memory data_memory_inst
    (
        .clk   (clk),
        .we    (dmem_we),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

    rv_core rv_core_inst
    (
        .clk            (clk),
        .rst            (rst),
        .run            (run),
        .imem_addr      (imem_addr),
        .instr          (instr),
        .dmem_addr      (dmem_addr),
        .dmem_we        (dmem_we),
        .dmem_wdata     (dmem_wdata),
        .dmem_rdata     (dmem_rdata),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_instr   (retire_instr),
        .retire_illegal (retire_illegal),
        .retire_rd_we   (retire_rd_we),
        .retire_rd      (retire_rd),
        .retire_rd_data (retire_rd_data),
        .retire_st_we   (retire_st_we),
        .retire_st_addr (retire_st_addr),
        .retire_st_data (retire_st_data)
    );

endmodule

//--- src/rv_core.sv
module rv_core
(
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    output rv_pkg::imem_addr_t imem_addr,
    input  rv_pkg::word_t      instr,
    output rv_pkg::dmem_addr_t dmem_addr,
    output logic               dmem_we,
    output rv_pkg::word_t      dmem_wdata,
    input  rv_pkg::word_t      dmem_rdata,
    output logic               retire_valid,
    output rv_pkg::pc_t        retire_pc,
    output rv_pkg::word_t      retire_instr,
    output logic               retire_illegal,
    output logic               retire_rd_we,
    output rv_pkg::reg_idx_t   retire_rd,
    output rv_pkg::word_t      retire_rd_data,
    output logic               retire_st_we,
    output rv_pkg::dmem_addr_t retire_st_addr,
    output rv_pkg::word_t      retire_st_data
);

    rv_pkg::pc_t      pc;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    imm;
    logic             use_imm;
    rv_pkg::alu_op_e  alu_op;
    logic             rd_we;
    logic             mem_read;
    logic             mem_write;
    logic             illegal;
    rv_pkg::word_t    rs1_data;
    rv_pkg::word_t    rs2_data;
    rv_pkg::word_t    alu_b;
    rv_pkg::word_t    alu_result;
    rv_pkg::word_t    wb_data;
    logic             reg_we;

    instruction_decoder instruction_decoder_inst
    (
        .instr     (instr),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .use_imm   (use_imm),
        .alu_op    (alu_op),
        .rd_we     (rd_we),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .illegal   (illegal)
    );

    register_file register_file_inst
    (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (reg_we),
        .rd       (rd),
        .rd_data  (wb_data)
    );

    assign alu_b = use_imm ? imm : rs2_data;

    always_comb
    begin
        case (alu_op)
            rv_pkg::alu_sub: alu_result = rs1_data - alu_b;
            rv_pkg::alu_and: alu_result = rs1_data & alu_b;
            rv_pkg::alu_or:  alu_result = rs1_data | alu_b;
            rv_pkg::alu_xor: alu_result = rs1_data ^ alu_b;
            default:         alu_result = rs1_data + alu_b;  // add, lw, sw
        endcase
    end

    assign wb_data = mem_read ? dmem_rdata : alu_result;  // load or alu
    assign reg_we  = run && rd_we;                        // nothing commits while loading

    assign imem_addr  = pc[11:2];
    assign dmem_addr  = alu_result[9:2];  // effective address, word granular
    assign dmem_we    = run && mem_write;
    assign dmem_wdata = rs2_data;

    // linear fetch, wraps after the last imem word
    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= '0;
        else if (run)
            pc <= (pc + 32'd4) & 32'h0000_0fff;
    end

    // trace control bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            retire_valid <= 1'b0;
            retire_rd_we <= 1'b0;
            retire_st_we <= 1'b0;
        end
        else
        begin
            retire_valid <= run;
            retire_rd_we <= reg_we && rd != '0;  // x0 target shows no write
            retire_st_we <= dmem_we;
        end
    end

    // trace payload, qualified by the bits above
    always_ff @(posedge clk)
    begin
        retire_pc      <= pc;
        retire_instr   <= instr;
        retire_illegal <= illegal;
        retire_rd      <= rd;
        retire_rd_data <= wb_data;
        retire_st_addr <= dmem_addr;
        retire_st_data <= rs2_data;
    end

    // fetch address stays on a word boundary
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

//--- src/data_memory.sv
module data_memory
(
    input  logic               clk,
    input  logic               we,
    input  rv_pkg::dmem_addr_t addr,   // word address, byte bits already dropped
    input  rv_pkg::word_t      wdata,
    output rv_pkg::word_t      rdata
);

    // contents survive reset
    rv_pkg::word_t mem [0:rv_pkg::DMEM_DEPTH-1];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wdata;  // sw commits at the edge
        end
    end

    assign rdata = mem[addr];  // lw data same cycle

endmodule

//--- src/instruction_decoder.sv
module instruction_decoder
(
    input  rv_pkg::word_t    instr,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::reg_idx_t rd,
    output rv_pkg::word_t    imm,
    output logic             use_imm,   // alu b from imm, not rs2
    output rv_pkg::alu_op_e  alu_op,
    output logic             rd_we,
    output logic             mem_read,
    output logic             mem_write,
    output logic             illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};               // sign extended
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};  // split field for sw

    assign imm = (opcode == rv_pkg::OPC_STORE) ? imm_s : imm_i;

    always_comb
    begin
        use_imm   = 1'b1;
        alu_op    = rv_pkg::alu_add;  // address calc default
        rd_we     = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP_IMM:
            begin
                rd_we = 1'b1;
                case (funct3)
                    rv_pkg::F3_ADD_SUB: alu_op = rv_pkg::alu_add;  // addi, no subi
                    rv_pkg::F3_XOR:     alu_op = rv_pkg::alu_xor;
                    rv_pkg::F3_OR:      alu_op = rv_pkg::alu_or;
                    rv_pkg::F3_AND:     alu_op = rv_pkg::alu_and;
                    default:            illegal = 1'b1;  // slti, shifts etc
                endcase
            end
            rv_pkg::OPC_OP:
            begin
                use_imm = 1'b0;
                rd_we   = 1'b1;
                if (funct7 == rv_pkg::F7_SUB && funct3 == rv_pkg::F3_ADD_SUB)
                    alu_op = rv_pkg::alu_sub;
                else if (funct7 != '0)
                    illegal = 1'b1;   // sra and friends, not supported
                else
                begin
                    case (funct3)
                        rv_pkg::F3_ADD_SUB: alu_op = rv_pkg::alu_add;
                        rv_pkg::F3_XOR:     alu_op = rv_pkg::alu_xor;
                        rv_pkg::F3_OR:      alu_op = rv_pkg::alu_or;
                        rv_pkg::F3_AND:     alu_op = rv_pkg::alu_and;
                        default:            illegal = 1'b1;
                    endcase
                end
            end
            rv_pkg::OPC_LOAD:
            begin
                rd_we    = 1'b1;
                mem_read = 1'b1;
                illegal  = (funct3 != rv_pkg::F3_WORD);  // lw only
            end
            rv_pkg::OPC_STORE:
            begin
                mem_write = 1'b1;
                illegal   = (funct3 != rv_pkg::F3_WORD);  // sw only
            end
            default: illegal = 1'b1;  // includes the all-zero word
        endcase

        // illegal retires as a no-op
        if (illegal)
        begin
            rd_we     = 1'b0;
            mem_read  = 1'b0;
            mem_write = 1'b0;
        end
    end

    always_comb
    begin
        assert (!(mem_read && mem_write));
    end

endmodule

//--- src/register_file.sv
module register_file
(
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    input  logic             we,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    rd_data
);

    rv_pkg::word_t regs [0:rv_pkg::REG_COUNT-1];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < rv_pkg::REG_COUNT; i++)
            begin
                regs[i] <= '0;  // architectural state starts at zero
            end
        end
        else if (we && rd != '0)  // x0 writes dropped
        begin
            regs[rd] <= rd_data;
        end
    end

    // x0 forced on the read side too
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // x0 must never pick up a value
    assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

//--- src/program_loader.sv
module program_loader
(
    input  logic               clk,
    input  logic               rst,
    input  logic               load_req,
    input  rv_pkg::imem_addr_t load_addr,
    input  rv_pkg::word_t      load_data,
    output logic               load_ack,
    input  logic               start,
    output logic               imem_we,
    output rv_pkg::imem_addr_t imem_waddr,
    output rv_pkg::word_t      imem_wdata,
    output logic               run
);

    rv_pkg::loader_state_e state;
    rv_pkg::imem_addr_t    waddr_q;  // captured with req
    rv_pkg::word_t         wdata_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= rv_pkg::ld_idle;
        end
        else
        begin
            case (state)
                rv_pkg::ld_idle:
                begin
                    if (start)
                        state <= rv_pkg::ld_run;    // start wins over a pending req
                    else if (load_req)
                        state <= rv_pkg::ld_write;
                end
                rv_pkg::ld_write: state <= rv_pkg::ld_ack;  // word lands this edge
                rv_pkg::ld_ack:
                begin
                    if (!load_req)
                        state <= rv_pkg::ld_idle;   // phase 4, ack drops next cycle
                end
                default: state <= rv_pkg::ld_run;   // run until reset
            endcase
        end
    end

    // payload capture on req
    always_ff @(posedge clk)
    begin
        if (state == rv_pkg::ld_idle && load_req)
        begin
            waddr_q <= load_addr;
            wdata_q <= load_data;
        end
    end

    assign imem_we    = (state == rv_pkg::ld_write);  // single write per handshake
    assign imem_waddr = waddr_q;
    assign imem_wdata = wdata_q;
    assign load_ack   = (state == rv_pkg::ld_ack);
    assign run        = (state == rv_pkg::ld_run);

    // run is sticky and the load port goes quiet for good
    assert property (@(posedge clk) disable iff (rst) run |=> run && !load_ack);

    // driver must hold the word it offered until ack is seen
    assert property (@(posedge clk) disable iff (rst)
        load_req && load_ack |-> $stable(load_addr) && load_addr == waddr_q);

endmodule

//--- src/instruction_memory.sv
module instruction_memory
(
    input  logic               clk,
    input  logic               we,     // loader write strobe
    input  rv_pkg::imem_addr_t waddr,
    input  rv_pkg::word_t      wdata,
    input  rv_pkg::imem_addr_t raddr,  // pc word address from the core
    output rv_pkg::word_t      rdata
);

    rv_pkg::word_t mem [0:rv_pkg::IMEM_DEPTH-1];

    // all-zero words are not a valid encoding, so
    // anything the loader never touches retires as illegal
    initial
    begin
        for (int i = 0; i < rv_pkg::IMEM_DEPTH; i++)
        begin
            mem[i] = '0;
        end
    end

    // one word per loader write cycle
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // fetch is combinational, the core sees the word in the same cycle
    assign rdata = mem[raddr];

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;    // data path width
    localparam int REG_COUNT  = 32;    // x0..x31
    localparam int IMEM_DEPTH = 1024;  // words
    localparam int DMEM_DEPTH = 256;   // words

    // major opcodes, bits 6:0
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_OP     = 7'b011_0011;
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;

    // funct3, bits 14:12
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;  // lw / sw only, no byte or half

    localparam logic [6:0] F7_SUB = 7'b010_0000;  // funct7 for sub, zero means add

    typedef logic [XLEN-1:0] word_t;       // register, memory and instruction word
    typedef logic [XLEN-1:0] pc_t;         // byte address of the fetch
    typedef logic [4:0]      reg_idx_t;    // rs1 / rs2 / rd
    typedef logic [9:0]      imem_addr_t;  // pc[11:2]
    typedef logic [7:0]      dmem_addr_t;  // effective address [9:2]

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_e;

    // boot sequencer states
    typedef enum logic [1:0] {
        ld_idle,   // waiting for a word or for start
        ld_write,  // imem write cycle
        ld_ack,    // ack held until req drops
        ld_run     // core running, left only by reset
    } loader_state_e;

endpackage
